/* hw/wb_isa_pkg.sv */
// ISA encodings for writeback: unit select bits, micro-op codes, trap causes
package wb_isa_pkg;

    // Functional unit select bits
    localparam int FU_ALU = 0;                          // Integer ALU
    localparam int FU_MUL = 1;                          // Multiplier
    localparam int FU_LSU = 2;                          // Load / store unit
    localparam int FU_CFU = 3;                          // Control flow unit

    // CFU micro-ops ------------------------------
    localparam logic [4:0] CFU_TAKEN  = 5'd1;           // Taken conditional branch
    localparam logic [4:0] CFU_JALI   = 5'd2;           // JAL, direct
    localparam logic [4:0] CFU_JALR   = 5'd3;           // JALR, indirect
    localparam logic [4:0] CFU_MRET   = 5'd4;           // Return from M-mode trap
    localparam logic [4:0] CFU_ECALL  = 5'd5;
    localparam logic [4:0] CFU_EBREAK = 5'd6;

    // LSU micro-op fields ------------------------
    localparam int LSU_LOAD   = 4;                      // Uop bit, load
    localparam int LSU_STORE  = 3;                      // Uop bit, store
    localparam int LSU_SIGNED = 0;                      // Uop bit, sign extend

    // Access size, uop bits 2:1
    localparam logic [1:0] LSU_BYTE = 2'd1;
    localparam logic [1:0] LSU_HALF = 2'd2;
    localparam logic [1:0] LSU_WORD = 2'd3;

    // Trap causes (mcause codes) -----------------
    localparam logic [5:0] TRAP_BREAKPT  = 6'd3;
    localparam logic [5:0] TRAP_LDACCESS = 6'd5;        // Load access fault
    localparam logic [5:0] TRAP_STACCESS = 6'd7;        // Store access fault
    localparam logic [5:0] TRAP_ECALLM   = 6'd11;       // ECALL from M-mode

endpackage

/* hw/wb_stage_pkg.sv */
// Writeback stage types: width typedefs and structs passed between units
package wb_stage_pkg;

    // Widths -------------------------------------
    typedef logic [31:0] xword_t;                       // Machine word
    typedef logic [4:0]  reg_addr_t;                    // GPR index
    typedef logic [4:0]  uop_t;                         // Micro-op code
    typedef logic [3:0]  fu_sel_t;                      // One-hot unit select
    typedef logic [1:0]  isize_t;                       // Instr size in halfwords
    typedef logic [5:0]  trap_cause_t;

    // Instruction held by the writeback stage
    typedef struct packed {
        reg_addr_t rd;                                  // Destination, or cause on trap
        xword_t    opr_a;                               // Result / strobe / target
        xword_t    opr_b;                               // Memory address for LSU
        uop_t      uop;
        fu_sel_t   fu;
        logic      trap;                                // Trap raised upstream
        isize_t    size;
    } s4_instr_t;

    // One unit's contribution to the GPR write
    typedef struct packed {
        logic   wen;
        xword_t wdata;
    } unit_wb_t;

    // GPR write port
    typedef struct packed {
        logic      wen;
        reg_addr_t rd;
        xword_t    wdata;
    } gpr_write_t;

    // Data memory response channel
    typedef struct packed {
        logic   recv;                                   // Response present
        logic   error;                                  // Bus error
        xword_t rdata;
    } dmem_rsp_t;

    // Trap report to the CSR block
    typedef struct packed {
        logic        cpu;                               // Trap taken by this instr
        trap_cause_t cause;
        xword_t      pc;
    } trap_info_t;

endpackage

/* hw/wb_flow_unit.sv */
// Writeback flow unit: PC register, control flow requests and target, trap cause
`timescale 1ns/100ps

module wb_flow_unit #(
    parameter wb_stage_pkg::xword_t PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  wb_stage_pkg::s4_instr_t  s4,              // Instruction in writeback
    input  logic                     s4_valid,
    input  logic                     pipe_progress,   // Instruction retires this cycle
    input  logic                     lsu_error,       // Bus error, live or captured
    input  logic                     lsu_store,       // Faulting access was a store
    input  wb_stage_pkg::xword_t     csr_mepc,
    input  wb_stage_pkg::xword_t     csr_mtvec,
    input  logic                     cf_ack,
    output logic                     cf_req,
    output wb_stage_pkg::xword_t     cf_target,
    output logic                     flow_busy,
    output logic                     exec_mret,       // Pulse on MRET retire
    output wb_stage_pkg::unit_wb_t   link_wb,         // Link register result
    output wb_stage_pkg::trap_info_t trap
);

    import wb_stage_pkg::*;
    import wb_isa_pkg::*;

    // Decode ------------------------------
    logic   fu_cfu;
    logic   cfu_taken;                                  // Branch, JAL or JALR
    logic   cfu_link;                                   // Writes next PC to rd
    logic   cfu_mret;
    logic   cfu_ecall;
    logic   cfu_ebreak;
    logic   up_trap;
    logic   any_trap;
    logic   req_raw;                                    // Some change wanted
    logic   cfu_done;                                   // Acked, still stalled
    logic   cf_accept;
    xword_t pc;
    xword_t n_pc;

    assign fu_cfu     = s4_valid && s4.fu[FU_CFU];
    assign cfu_taken  = fu_cfu && (s4.uop == CFU_TAKEN ||
                                   s4.uop == CFU_JALI  ||
                                   s4.uop == CFU_JALR);
    assign cfu_link   = fu_cfu && (s4.uop == CFU_JALI || s4.uop == CFU_JALR);
    assign cfu_mret   = fu_cfu && s4.uop == CFU_MRET;
    assign cfu_ecall  = fu_cfu && s4.uop == CFU_ECALL;
    assign cfu_ebreak = fu_cfu && s4.uop == CFU_EBREAK;
    assign up_trap    = s4_valid && s4.trap;            // Flagged by an earlier stage

    // Every trap source funnels into mtvec
    assign any_trap = cfu_ecall || cfu_ebreak || up_trap || lsu_error;
    assign req_raw  = cfu_taken || cfu_mret || any_trap;

    // Request ------------------------------
    assign cf_req    = req_raw && !cfu_done;            // Once per instruction
    assign cf_accept = cf_req && cf_ack;
    assign flow_busy = cf_req && !cf_ack;

    // Trap vector wins over jump and return targets
    assign cf_target = any_trap ? csr_mtvec :
                       ({32{cfu_taken}} & s4.opr_a) |
                       ({32{cfu_mret}}  & csr_mepc);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && (cfu_done || cf_accept);
        end
    end

    // PC ------------------------------
    assign n_pc = pc + xword_t'({s4.size, 1'b0});      // Size is in halfwords

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= PC_RESET_VALUE;
        end else if (cf_accept) begin
            pc <= cf_target;                            // Redirect
        end else if (pipe_progress && !cfu_done) begin
            pc <= n_pc;                                 // Sequential, not after a redirect
        end
    end

    assign exec_mret     = cfu_mret && pipe_progress;
    assign link_wb.wen   = cfu_link;
    assign link_wb.wdata = n_pc;                        // Return address

    // Trap report ------------------------------
    assign trap.cpu = any_trap;
    assign trap.pc  = pc;

    // Bus errors first, then the CFU traps, then the upstream cause in rd
    assign trap.cause = lsu_error && !lsu_store ? TRAP_LDACCESS :
                        lsu_error               ? TRAP_STACCESS :
                        cfu_ebreak              ? TRAP_BREAKPT  :
                        cfu_ecall               ? TRAP_ECALLM   :
                                                  {1'b0, s4.rd};

    // A pending request may not drop or move before the front end takes it
    property cf_req_held_p;
        @(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target);
    endproperty

    cf_req_held_a: assert property (cf_req_held_p)
        else $error("cf_req changed before cf_ack");

endmodule

/* hw/wb_load_unit.sv */
// Writeback load unit: response tracking, bus error capture, read data alignment
`timescale 1ns/100ps

module wb_load_unit (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_stage_pkg::s4_instr_t s4,
    input  logic                    s4_valid,
    input  logic                    pipe_progress,
    input  wb_stage_pkg::dmem_rsp_t dmem_rsp,
    output logic                    dmem_ack,           // Response expected
    output logic                    load_busy,
    output logic                    lsu_error,
    output logic                    lsu_store,
    output wb_stage_pkg::unit_wb_t  load_wb
);

    import wb_stage_pkg::*;
    import wb_isa_pkg::*;

    logic       lsu_active;
    logic       lsu_load;
    logic       rsp_seen;                               // Response taken, still stalled
    logic       rsp_accept;                             // Response taken this cycle
    logic       err_seen;                               // Captured bus error
    logic [3:0] strb;
    logic [1:0] offset;
    logic [1:0] acc_size;
    logic       sign_ext;
    xword_t     masked;
    xword_t     lane_data;
    xword_t     ext_data;

    // Trapped instructions never reached the bus
    assign lsu_active = s4_valid && s4.fu[FU_LSU] && !s4.trap;
    assign lsu_load   = lsu_active && s4.uop[LSU_LOAD];
    assign lsu_store  = lsu_active && s4.uop[LSU_STORE];

    // Response tracking ------------------------------
    assign dmem_ack   = lsu_active && !rsp_seen;
    assign rsp_accept = dmem_rsp.recv && dmem_ack;
    assign load_busy  = dmem_ack && !dmem_rsp.recv;     // Still waiting

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen <= 1'b0;
        end else begin
            rsp_seen <= !pipe_progress && (rsp_seen || rsp_accept);
        end
    end

    // Error stays up until the trap retires
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            err_seen <= 1'b0;
        end else if (pipe_progress) begin
            err_seen <= 1'b0;
        end else if (rsp_accept && dmem_rsp.error) begin
            err_seen <= 1'b1;
        end
    end

    assign lsu_error = err_seen || (rsp_accept && dmem_rsp.error);

    // Alignment ------------------------------
    assign strb     = s4.opr_a[3:0];                    // Byte lanes from memory stage
    assign offset   = s4.opr_b[1:0];
    assign acc_size = s4.uop[2:1];
    assign sign_ext = s4.uop[LSU_SIGNED];

    // Drop lanes outside the access, then move to bit 0
    assign masked    = dmem_rsp.rdata & {{8{strb[3]}}, {8{strb[2]}},
                                         {8{strb[1]}}, {8{strb[0]}}};
    assign lane_data = masked >> {offset, 3'b000};

    always_comb begin
        case (acc_size)
            LSU_BYTE: ext_data = {{24{sign_ext && lane_data[7]}}, lane_data[7:0]};
            LSU_HALF: ext_data = {{16{sign_ext && lane_data[15]}}, lane_data[15:0]};
            LSU_WORD: ext_data = lane_data;
            default:  ext_data = lane_data;             // Unused encoding
        endcase
    end

    // Only a clean load response writes rd
    assign load_wb.wen   = lsu_load && rsp_accept && !dmem_rsp.error;
    assign load_wb.wdata = ext_data;

    // Memory must not answer again while the stage sits on a taken response
    property no_extra_rsp_p;
        @(posedge g_clk) disable iff (!g_resetn)
        rsp_seen |-> !dmem_rsp.recv;
    endproperty

    no_extra_rsp_a: assert property (no_extra_rsp_p)
        else $error("dmem response with no outstanding access");

endmodule

/* hw/wb_retire_ctrl.sv */
// Writeback retire control: stage busy and progress, GPR write select, forwarding
`timescale 1ns/100ps

module wb_retire_ctrl (
    input  wb_stage_pkg::s4_instr_t  s4,
    input  logic                     s4_valid,
    input  logic                     flow_busy,         // Waiting for cf_ack
    input  logic                     load_busy,         // Waiting for memory
    input  wb_stage_pkg::unit_wb_t   link_wb,
    input  wb_stage_pkg::unit_wb_t   load_wb,
    output logic                     s4_busy,
    output logic                     pipe_progress,
    output wb_stage_pkg::gpr_write_t gpr,
    output wb_stage_pkg::reg_addr_t  fwd_rd,
    output wb_stage_pkg::xword_t     fwd_wdata
);

    import wb_stage_pkg::*;
    import wb_isa_pkg::*;

    logic   alu_wen;
    logic   mul_wen;
    xword_t pass_data;                                  // ALU / MUL result

    // Stall and retire ------------------------------
    assign s4_busy       = s4_valid && (flow_busy || load_busy);
    assign pipe_progress = s4_valid && !s4_busy;

    // Results computed upstream arrive in operand A
    assign alu_wen   = s4_valid && s4.fu[FU_ALU];
    assign mul_wen   = s4_valid && s4.fu[FU_MUL];
    assign pass_data = s4.opr_a;

    // GPR write ------------------------------
    assign gpr.wen   = !s4.trap &&
                       (alu_wen || mul_wen || link_wb.wen || load_wb.wen);
    assign gpr.rd    = s4.rd;
    assign gpr.wdata = ({32{alu_wen || mul_wen}} & pass_data)     |
                       ({32{link_wb.wen}}        & link_wb.wdata) |
                       ({32{load_wb.wen}}        & load_wb.wdata);

    assign fwd_rd    = s4.rd;                           // Bypass to decode
    assign fwd_wdata = gpr.wdata;

    // Units in separate blocks must never claim the port together
    always_comb begin
        one_writer_a: assert ($onehot0({alu_wen, mul_wen, link_wb.wen, load_wb.wen}))
            else $error("more than one unit writes the GPR");
    end

endmodule

/* hw/wb_stage_top.sv */
// Writeback stage top level: flow, load and retire units wired together
`timescale 1ns/100ps

module wb_stage_top #(
    parameter wb_stage_pkg::xword_t PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    // Upstream
    input  wb_stage_pkg::s4_instr_t  s4,
    input  logic                     s4_valid,
    output logic                     s4_busy,
    // Control flow to the front end
    output logic                     cf_req,
    output wb_stage_pkg::xword_t     cf_target,
    input  logic                     cf_ack,
    // Data memory response
    input  wb_stage_pkg::dmem_rsp_t  dmem_rsp,
    output logic                     dmem_ack,
    // GPR write and forwarding
    output wb_stage_pkg::gpr_write_t gpr,
    output wb_stage_pkg::reg_addr_t  fwd_rd,
    output wb_stage_pkg::xword_t     fwd_wdata,
    // CSR side
    output wb_stage_pkg::trap_info_t trap,
    output logic                     exec_mret,
    input  wb_stage_pkg::xword_t     csr_mepc,
    input  wb_stage_pkg::xword_t     csr_mtvec
);

    import wb_stage_pkg::*;

    logic     pipe_progress;
    logic     flow_busy;
    logic     load_busy;
    logic     lsu_error;                                // Load unit to trap logic
    logic     lsu_store;
    unit_wb_t link_wb;
    unit_wb_t load_wb;

    wb_flow_unit #(
        .PC_RESET_VALUE (PC_RESET_VALUE)
    ) u_flow (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .s4            (s4),
        .s4_valid      (s4_valid),
        .pipe_progress (pipe_progress),
        .lsu_error     (lsu_error),
        .lsu_store     (lsu_store),
        .csr_mepc      (csr_mepc),
        .csr_mtvec     (csr_mtvec),
        .cf_ack        (cf_ack),
        .cf_req        (cf_req),
        .cf_target     (cf_target),
        .flow_busy     (flow_busy),
        .exec_mret     (exec_mret),
        .link_wb       (link_wb),
        .trap          (trap)
    );

    wb_load_unit u_load (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .s4            (s4),
        .s4_valid      (s4_valid),
        .pipe_progress (pipe_progress),
        .dmem_rsp      (dmem_rsp),
        .dmem_ack      (dmem_ack),
        .load_busy     (load_busy),
        .lsu_error     (lsu_error),
        .lsu_store     (lsu_store),
        .load_wb       (load_wb)
    );

    wb_retire_ctrl u_retire (
        .s4            (s4),
        .s4_valid      (s4_valid),
        .flow_busy     (flow_busy),
        .load_busy     (load_busy),
        .link_wb       (link_wb),
        .load_wb       (load_wb),
        .s4_busy       (s4_busy),
        .pipe_progress (pipe_progress),
        .gpr           (gpr),
        .fwd_rd        (fwd_rd),
        .fwd_wdata     (fwd_wdata)
    );

endmodule

/* tests/tb_wb_stage.sv */
// Testbench for the writeback stage: stimulus table, memory and acknowledge models, PC model
`timescale 1ns/100ps

module tb_wb_stage;

    import wb_stage_pkg::*;
    import wb_isa_pkg::*;

    localparam xword_t PC_RESET = 32'h0001_0000;         // Overrides the default reset PC
    localparam xword_t MTVEC    = 32'h0001_0100;         // Trap vector
    localparam xword_t MEPC     = 32'h0001_0444;
    localparam xword_t RDATA    = 32'hc324_85f6;         // Bytes f6 85 24 c3 from lane 0 up
    localparam int     TIMEOUT  = 50;                    // Cycles allowed per row
    localparam int     SEED     = 84096;

    // Unit selects and LSU micro-ops ------------------------
    localparam fu_sel_t ALU = fu_sel_t'(1 << FU_ALU);
    localparam fu_sel_t MUL = fu_sel_t'(1 << FU_MUL);
    localparam fu_sel_t LSU = fu_sel_t'(1 << FU_LSU);
    localparam fu_sel_t CFU = fu_sel_t'(1 << FU_CFU);
    localparam uop_t    LB  = {1'b1, 1'b0, LSU_BYTE, 1'b1};
    localparam uop_t    LBU = {1'b1, 1'b0, LSU_BYTE, 1'b0};
    localparam uop_t    LH  = {1'b1, 1'b0, LSU_HALF, 1'b1};
    localparam uop_t    LHU = {1'b1, 1'b0, LSU_HALF, 1'b0};
    localparam uop_t    LW  = {1'b1, 1'b0, LSU_WORD, 1'b0};
    localparam uop_t    SW  = {1'b0, 1'b1, LSU_WORD, 1'b0};

    // One table row
    typedef struct packed {
        s4_instr_t   instr;
        xword_t      rdata;                              // Memory model answer
        logic        mem_err;
        logic [2:0]  mem_dly;                            // Cycles of dmem_ack before recv
        logic [2:0]  ack_dly;                            // Cycles of cf_req before cf_ack
        logic        exp_wen;
        logic        exp_link;                           // Write data is PC + size*2
        xword_t      exp_wdata;
        logic        exp_cf;
        xword_t      exp_target;
        trap_cause_t exp_cause;                          // Zero when no trap
        logic        exp_mret;
    } row_t;

    logic       g_clk = 1'b0;
    logic       g_resetn;
    s4_instr_t  s4;
    logic       s4_valid;
    logic       s4_busy;
    logic       cf_req;
    xword_t     cf_target;
    logic       cf_ack;
    dmem_rsp_t  dmem_rsp;
    logic       dmem_ack;
    gpr_write_t gpr;
    reg_addr_t  fwd_rd;
    xword_t     fwd_wdata;
    trap_info_t trap;
    logic       exec_mret;
    xword_t     csr_mepc;
    xword_t     csr_mtvec;

    row_t   rows[$];
    string  names[$];
    xword_t model_pc;                                    // PC the stage should report
    int     row_errs;
    int     n_pass;
    int     n_fail;
    logic   timed_out;

    always #4 g_clk = ~g_clk;                            // 8 ns period

    wb_stage_top #(
        .PC_RESET_VALUE (PC_RESET)
    ) DUT (.*);

    function automatic s4_instr_t make_instr(input reg_addr_t rd, input xword_t a,
                                             input xword_t b, input uop_t uop,
                                             input fu_sel_t fu, input logic trp,
                                             input isize_t size);
        s4_instr_t i;
        i.rd    = rd;
        i.opr_a = a;
        i.opr_b = b;
        i.uop   = uop;
        i.fu    = fu;
        i.trap  = trp;
        i.size  = size;
        return i;
    endfunction

    task automatic add_row(input string name, input s4_instr_t instr, input xword_t rdata,
                           input logic mem_err, input logic exp_wen, input logic exp_link,
                           input xword_t exp_wdata, input logic exp_cf,
                           input xword_t exp_target, input trap_cause_t exp_cause,
                           input logic exp_mret);
        row_t r;
        r.instr      = instr;
        r.rdata      = rdata;
        r.mem_err    = mem_err;
        r.mem_dly    = 3'(1 + $urandom % 4);            // Random back-pressure
        r.ack_dly    = 3'(1 + $urandom % 3);
        r.exp_wen    = exp_wen;
        r.exp_link   = exp_link;
        r.exp_wdata  = exp_wdata;
        r.exp_cf     = exp_cf;
        r.exp_target = exp_target;
        r.exp_cause  = exp_cause;
        r.exp_mret   = exp_mret;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // Stimulus table ------------------------------
    task automatic build_table();
        add_row("alu", make_instr(5'd5, 32'h1234_5678, '0, '0, ALU, 1'b0, 2'd2),
                '0, 1'b0, 1'b1, 1'b0, 32'h1234_5678, 1'b0, '0, '0, 1'b0);
        add_row("mul", make_instr(5'd6, 32'hdead_beef, '0, '0, MUL, 1'b0, 2'd1),
                '0, 1'b0, 1'b1, 1'b0, 32'hdead_beef, 1'b0, '0, '0, 1'b0);
        add_row("alu upstream trap", make_instr(5'd2, '0, '0, '0, ALU, 1'b1, 2'd2),
                '0, 1'b0, 1'b0, 1'b0, '0, 1'b1, MTVEC, 6'd2, 1'b0);
        // Loads with strobe in opr_a and offset in opr_b
        add_row("lb off0", make_instr(5'd7, 32'h1, 32'h1000, LB, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'hffff_fff6, 1'b0, '0, '0, 1'b0);
        add_row("lbu off1", make_instr(5'd7, 32'h2, 32'h1001, LBU, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'h0000_0085, 1'b0, '0, '0, 1'b0);
        add_row("lb off2", make_instr(5'd7, 32'h4, 32'h1002, LB, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'h0000_0024, 1'b0, '0, '0, 1'b0);
        add_row("lb off3", make_instr(5'd7, 32'h8, 32'h1003, LB, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'hffff_ffc3, 1'b0, '0, '0, 1'b0);
        add_row("lbu off3", make_instr(5'd7, 32'h8, 32'h1003, LBU, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'h0000_00c3, 1'b0, '0, '0, 1'b0);
        add_row("lh off0", make_instr(5'd7, 32'h3, 32'h1000, LH, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'hffff_85f6, 1'b0, '0, '0, 1'b0);
        add_row("lhu off2", make_instr(5'd7, 32'hc, 32'h1002, LHU, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'h0000_c324, 1'b0, '0, '0, 1'b0);
        add_row("lh off2", make_instr(5'd7, 32'hc, 32'h1002, LH, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'hffff_c324, 1'b0, '0, '0, 1'b0);
        add_row("lw", make_instr(5'd7, 32'hf, 32'h1000, LW, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b1, 1'b0, 32'hc324_85f6, 1'b0, '0, '0, 1'b0);
        // Jumps and branches redirect the PC of the next row
        add_row("jal", make_instr(5'd1, 32'h0001_0200, '0, CFU_JALI, CFU, 1'b0, 2'd2),
                '0, 1'b0, 1'b1, 1'b1, '0, 1'b1, 32'h0001_0200, '0, 1'b0);
        add_row("alu after jal", make_instr(5'd8, 32'h55, '0, '0, ALU, 1'b0, 2'd2),
                '0, 1'b0, 1'b1, 1'b0, 32'h55, 1'b0, '0, '0, 1'b0);
        add_row("jalr", make_instr(5'd1, 32'h0001_0340, '0, CFU_JALR, CFU, 1'b0, 2'd1),
                '0, 1'b0, 1'b1, 1'b1, '0, 1'b1, 32'h0001_0340, '0, 1'b0);
        add_row("branch", make_instr(5'd0, 32'h0001_0380, '0, CFU_TAKEN, CFU, 1'b0, 2'd2),
                '0, 1'b0, 1'b0, 1'b0, '0, 1'b1, 32'h0001_0380, '0, 1'b0);
        // Traps
        add_row("ecall", make_instr(5'd0, '0, '0, CFU_ECALL, CFU, 1'b0, 2'd2),
                '0, 1'b0, 1'b0, 1'b0, '0, 1'b1, MTVEC, TRAP_ECALLM, 1'b0);
        add_row("ebreak", make_instr(5'd0, '0, '0, CFU_EBREAK, CFU, 1'b0, 2'd1),
                '0, 1'b0, 1'b0, 1'b0, '0, 1'b1, MTVEC, TRAP_BREAKPT, 1'b0);
        add_row("load bus error", make_instr(5'd9, 32'hf, 32'h2000, LW, LSU, 1'b0, 2'd2),
                RDATA, 1'b1, 1'b0, 1'b0, '0, 1'b1, MTVEC, TRAP_LDACCESS, 1'b0);
        add_row("store bus error", make_instr(5'd0, 32'hf, 32'h2004, SW, LSU, 1'b0, 2'd2),
                RDATA, 1'b1, 1'b0, 1'b0, '0, 1'b1, MTVEC, TRAP_STACCESS, 1'b0);
        add_row("store", make_instr(5'd0, 32'hf, 32'h2008, SW, LSU, 1'b0, 2'd2),
                RDATA, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0);
        add_row("mret", make_instr(5'd0, '0, '0, CFU_MRET, CFU, 1'b0, 2'd2),
                '0, 1'b0, 1'b0, 1'b0, '0, 1'b1, MEPC, '0, 1'b1);
        add_row("alu after mret", make_instr(5'd9, 32'h99, '0, '0, ALU, 1'b0, 2'd2),
                '0, 1'b0, 1'b1, 1'b0, 32'h99, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic note_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        row_errs++;
    endtask

    task automatic finish_row(input string name);
        if (row_errs == 0) begin
            n_pass++;
            $display("Row %s: pass", name);
        end else begin
            n_fail++;
            $display("Row %s: fail, %0d mismatches", name, row_errs);
        end
    endtask

    // Checks ------------------------------
    task automatic check_reset();
        row_errs = 0;
        @(negedge g_clk);
        if (trap.pc !== PC_RESET)
            note_error($sformatf("trap.pc after reset is %h, expected %h", trap.pc, PC_RESET));
        if ({cf_req, dmem_ack, gpr.wen, exec_mret, s4_busy} !== 5'b0)
            note_error("an output is active after reset");
        finish_row("reset");
    endtask

    // Sampled on the retire cycle before the PC model steps
    task automatic check_retire(input row_t r);
        xword_t exp_data;
        exp_data = r.exp_link ? model_pc + 32'(r.instr.size) * 2 : r.exp_wdata;
        if (gpr.wen !== r.exp_wen)
            note_error($sformatf("gpr.wen is %b, expected %b", gpr.wen, r.exp_wen));
        if (r.exp_wen && gpr.rd !== r.instr.rd)
            note_error($sformatf("gpr.rd is %0d, expected %0d", gpr.rd, r.instr.rd));
        if (r.exp_wen && gpr.wdata !== exp_data)
            note_error($sformatf("gpr.wdata is %h, expected %h", gpr.wdata, exp_data));
        if (fwd_rd !== r.instr.rd)
            note_error($sformatf("fwd_rd is %0d, expected %0d", fwd_rd, r.instr.rd));
        if (r.exp_wen && fwd_wdata !== exp_data)
            note_error($sformatf("fwd_wdata is %h, expected %h", fwd_wdata, exp_data));
        if (!r.mem_err && dmem_ack !== r.instr.fu[FU_LSU])
            note_error($sformatf("dmem_ack is %b, expected %b",
                                 dmem_ack, r.instr.fu[FU_LSU]));
        if (cf_req !== r.exp_cf)
            note_error($sformatf("cf_req is %b, expected %b", cf_req, r.exp_cf));
        if (r.exp_cf && cf_target !== r.exp_target)
            note_error($sformatf("cf_target is %h, expected %h", cf_target, r.exp_target));
        if (trap.cpu !== (r.exp_cause != '0))
            note_error($sformatf("trap.cpu is %b", trap.cpu));
        if (r.exp_cause != '0 && trap.cause !== r.exp_cause)
            note_error($sformatf("trap.cause is %0d, expected %0d", trap.cause, r.exp_cause));
        if (trap.pc !== model_pc)
            note_error($sformatf("trap.pc is %h, expected %h", trap.pc, model_pc));
        if (exec_mret !== r.exp_mret)
            note_error($sformatf("exec_mret is %b, expected %b", exec_mret, r.exp_mret));
        if (r.exp_cf) begin
            model_pc = r.exp_target;                     // Redirect taken
        end else begin
            model_pc = model_pc + 32'(r.instr.size) * 2;
        end
    endtask

    // Presents one row and plays memory and front end until it retires
    task automatic run_row(input row_t r, input string name);
        int   cyc;
        int   req_cnt;
        int   mem_cnt;
        logic sent;
        logic retired;
        cyc      = 0;
        req_cnt  = 0;
        mem_cnt  = 0;
        sent     = 1'b0;
        retired  = 1'b0;
        row_errs = 0;
        @(posedge g_clk);
        s4       <= r.instr;
        s4_valid <= 1'b1;
        cf_ack   <= 1'b0;
        dmem_rsp <= '0;
        while (!retired && cyc < TIMEOUT) begin
            @(negedge g_clk);
            if (!s4_busy) begin
                check_retire(r);
                retired = 1'b1;
            end else begin
                if (exec_mret)
                    note_error("exec_mret high on a stalled cycle");
                if (r.instr.fu[FU_LSU] && gpr.wen)
                    note_error("gpr.wen high while the memory access is stalled");
                if (cf_req && !r.exp_cf)
                    note_error("cf_req raised with no change expected");
                if (cf_req && cf_target !== r.exp_target)   // Must hold under back-pressure
                    note_error($sformatf("stalled cf_target is %h, expected %h",
                                         cf_target, r.exp_target));
                if (cf_req)
                    req_cnt++;
                if (dmem_ack)
                    mem_cnt++;
                @(posedge g_clk);
                cf_ack <= (req_cnt >= int'(r.ack_dly));
                if (!sent && mem_cnt >= int'(r.mem_dly)) begin
                    dmem_rsp <= {1'b1, r.mem_err, r.rdata}; // Single-cycle response
                    sent = 1'b1;
                end else begin
                    dmem_rsp <= '0;
                end
                cyc++;
            end
        end
        if (!retired) begin
            $display("Row %s did not retire within %0d cycles", name, TIMEOUT);
            row_errs++;
            timed_out = 1'b1;
        end else if (!r.exp_cf && !r.instr.fu[FU_LSU] && cyc != 0) begin
            note_error($sformatf("plain instruction stalled for %0d cycles", cyc));
        end
        finish_row($sformatf("%s (mem %0d, ack %0d)", name, r.mem_dly, r.ack_dly));
    endtask

    // Main sequence ------------------------------
    initial begin
        int seed_set;
        g_resetn  = 1'b0;
        s4        = '0;
        s4_valid  = 1'b0;
        cf_ack    = 1'b0;
        dmem_rsp  = '0;
        csr_mepc  = MEPC;
        csr_mtvec = MTVEC;
        model_pc  = PC_RESET;
        n_pass    = 0;
        n_fail    = 0;
        timed_out = 1'b0;
        seed_set  = $urandom(SEED);                      // Seeds every later draw
        build_table();
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
        check_reset();
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            run_row(rows[i], names[i]);
        end
        @(posedge g_clk);
        s4_valid <= 1'b0;
        cf_ack   <= 1'b0;
        dmem_rsp <= '0;
        $display("Rows passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/wb_isa_pkg.sv
hw/wb_stage_pkg.sv
hw/wb_flow_unit.sv
hw/wb_load_unit.sv
hw/wb_retire_ctrl.sv
hw/wb_stage_top.sv
tests/tb_wb_stage.sv

/* Makefile */
TOP = tb_wb_stage
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
